// File: mem_msg_pkg.sv
package mem_msg_pkg;

  // Word address
  typedef logic [19:0] addr_t;

  typedef logic [31:0] data_t;

  // Returned unchanged with the response
  typedef logic [3:0] tag_t;

  // Local device number
  typedef logic [1:0] dev_sel_t;

  typedef enum logic
  {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } mem_op_e;

endpackage

// File: tile_map_pkg.sv
package tile_map_pkg;

  // Device numbers as stored in the order FIFO
  localparam mem_msg_pkg::dev_sel_t DEV_MEM  = 2'd0;
  localparam mem_msg_pkg::dev_sel_t DEV_CFG  = 2'd1;
  localparam mem_msg_pkg::dev_sel_t DEV_LOOP = 2'd2;

  // Set means a memory address
  localparam int MEM_WINDOW_BIT = 19;

  // Device field sits between this bit and the memory window bit
  localparam int DEV_FIELD_LSB = 16;

  localparam logic [2:0] FIELD_MEM = 3'd1;
  localparam logic [2:0] FIELD_CFG = 3'd2;

  // Config register indexes in the low address bits
  localparam logic [3:0] CFG_REG_ID       = 4'd0;
  localparam logic [3:0] CFG_REG_SCRATCH0 = 4'd1;
  localparam logic [3:0] CFG_REG_SCRATCH1 = 4'd2;

  typedef logic [7:0] did_t;

endpackage

// File: mem_msg_if.sv
`timescale 1ns/10ps

interface mem_msg_if;

  import mem_msg_pkg::*;

  logic    v;
  logic    ready;
  mem_op_e op;
  addr_t   addr;
  data_t   data;
  tag_t    tag;
  // Responses only
  logic    err;

  modport src
  (
    output v, op, addr, data, tag, err,
    input  ready
  );

  modport snk
  (
    input  v, op, addr, data, tag, err,
    output ready
  );

endinterface

// File: dev_xbar.sv
`timescale 1ns/10ps

module dev_xbar
#(
  parameter int ORDER_DEPTH = 4
)
(
  input  logic                 clk_i,
  input  logic                 rst_n_i,

  input  logic                 req_v_i,
  input  mem_msg_pkg::mem_op_e req_op_i,
  input  mem_msg_pkg::addr_t   req_addr_i,
  input  mem_msg_pkg::data_t   req_data_i,
  input  mem_msg_pkg::tag_t    req_tag_i,
  output logic                 req_ready_o,

  output logic                 resp_v_o,
  output mem_msg_pkg::mem_op_e resp_op_o,
  output mem_msg_pkg::addr_t   resp_addr_o,
  output mem_msg_pkg::data_t   resp_data_o,
  output mem_msg_pkg::tag_t    resp_tag_o,
  output logic                 resp_err_o,
  input  logic                 resp_ready_i,

  mem_msg_if.src               mem_req_o,
  mem_msg_if.src               cfg_req_o,
  mem_msg_if.src               loop_req_o,
  mem_msg_if.snk               mem_rsp_i,
  mem_msg_if.snk               cfg_rsp_i,
  mem_msg_if.snk               loop_rsp_i
);

  import mem_msg_pkg::*;
  import tile_map_pkg::*;

  localparam int PTR_W = (ORDER_DEPTH > 1) ? $clog2(ORDER_DEPTH) : 1;
  localparam int CNT_W = $clog2(ORDER_DEPTH + 1);

  logic [2:0]       dev_field;
  logic             is_mem;
  logic             is_cfg;
  logic             is_loop;
  logic [2:0]       sel_oh;
  dev_sel_t         sel_dev;
  logic             sel_ready;
  logic             fifo_full;
  logic             fifo_empty;
  logic             push;
  logic             pop;
  dev_sel_t         order_q [ORDER_DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  dev_sel_t         head_dev;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(ORDER_DEPTH - 1))
      return '0;
    return ptr + 1'b1;
  endfunction

  // Device field only counts outside the memory window
  assign dev_field = req_addr_i[MEM_WINDOW_BIT-1:DEV_FIELD_LSB];
  assign is_mem    = req_addr_i[MEM_WINDOW_BIT] || (dev_field == FIELD_MEM);
  assign is_cfg    = !req_addr_i[MEM_WINDOW_BIT] && (dev_field == FIELD_CFG);
  assign is_loop   = !is_mem && !is_cfg;

  always_comb
  begin
    sel_oh          = '0;
    sel_oh[DEV_MEM] = is_mem;
    sel_oh[DEV_CFG] = is_cfg;
    sel_oh[DEV_LOOP] = is_loop;
    if (is_mem)
      sel_dev = DEV_MEM;
    else if (is_cfg)
      sel_dev = DEV_CFG;
    else
      sel_dev = DEV_LOOP;
  end

  always_comb
  begin
    case (sel_dev)
      DEV_MEM: sel_ready = mem_req_o.ready;
      DEV_CFG: sel_ready = cfg_req_o.ready;
      default: sel_ready = loop_req_o.ready;
    endcase
  end

  assign fifo_full   = (count_q == CNT_W'(ORDER_DEPTH));
  assign fifo_empty  = (count_q == '0);
  assign req_ready_o = sel_ready && !fifo_full;
  assign push        = req_v_i && req_ready_o;

  // Valid reaches only the selected device, and only with FIFO room
  assign mem_req_o.v  = req_v_i && !fifo_full && sel_oh[DEV_MEM];
  assign cfg_req_o.v  = req_v_i && !fifo_full && sel_oh[DEV_CFG];
  assign loop_req_o.v = req_v_i && !fifo_full && sel_oh[DEV_LOOP];

  assign mem_req_o.op    = req_op_i;
  assign mem_req_o.addr  = req_addr_i;
  assign mem_req_o.data  = req_data_i;
  assign mem_req_o.tag   = req_tag_i;
  assign mem_req_o.err   = 1'b0;
  assign cfg_req_o.op    = req_op_i;
  assign cfg_req_o.addr  = req_addr_i;
  assign cfg_req_o.data  = req_data_i;
  assign cfg_req_o.tag   = req_tag_i;
  assign cfg_req_o.err   = 1'b0;
  assign loop_req_o.op   = req_op_i;
  assign loop_req_o.addr = req_addr_i;
  assign loop_req_o.data = req_data_i;
  assign loop_req_o.tag  = req_tag_i;
  assign loop_req_o.err  = 1'b0;

  // Only the device at the FIFO head may answer
  assign head_dev = order_q[rd_ptr_q];

  always_comb
  begin
    case (head_dev)
      DEV_MEM:
      begin
        resp_v_o    = mem_rsp_i.v && !fifo_empty;
        resp_op_o   = mem_rsp_i.op;
        resp_addr_o = mem_rsp_i.addr;
        resp_data_o = mem_rsp_i.data;
        resp_tag_o  = mem_rsp_i.tag;
        resp_err_o  = mem_rsp_i.err;
      end
      DEV_CFG:
      begin
        resp_v_o    = cfg_rsp_i.v && !fifo_empty;
        resp_op_o   = cfg_rsp_i.op;
        resp_addr_o = cfg_rsp_i.addr;
        resp_data_o = cfg_rsp_i.data;
        resp_tag_o  = cfg_rsp_i.tag;
        resp_err_o  = cfg_rsp_i.err;
      end
      default:
      begin
        resp_v_o    = loop_rsp_i.v && !fifo_empty;
        resp_op_o   = loop_rsp_i.op;
        resp_addr_o = loop_rsp_i.addr;
        resp_data_o = loop_rsp_i.data;
        resp_tag_o  = loop_rsp_i.tag;
        resp_err_o  = loop_rsp_i.err;
      end
    endcase
  end

  assign mem_rsp_i.ready  = resp_ready_i && !fifo_empty && (head_dev == DEV_MEM);
  assign cfg_rsp_i.ready  = resp_ready_i && !fifo_empty && (head_dev == DEV_CFG);
  assign loop_rsp_i.ready = resp_ready_i && !fifo_empty && (head_dev == DEV_LOOP);
  assign pop              = resp_v_o && resp_ready_i;

  always_ff @(posedge clk_i)
  begin
    if (push)
      order_q[wr_ptr_q] <= sel_dev;
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end
    else
    begin
      if (push)
        wr_ptr_q <= next_ptr(wr_ptr_q);
      if (pop)
        rd_ptr_q <= next_ptr(rd_ptr_q);
      count_q <= count_q + CNT_W'(push) - CNT_W'(pop);
    end
  end

  // Each FIFO entry stands for one response held in a device
  a_fifo_occupancy: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    count_q == CNT_W'(mem_rsp_i.v) + CNT_W'(cfg_rsp_i.v) + CNT_W'(loop_rsp_i.v));

  a_sel_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    push |-> $onehot({mem_req_o.v && mem_req_o.ready, cfg_req_o.v && cfg_req_o.ready,
                      loop_req_o.v && loop_req_o.ready}));

endmodule

// File: cfg_slice.sv
`timescale 1ns/10ps

module cfg_slice
(
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  tile_map_pkg::did_t did_i,
  mem_msg_if.snk             req_i,
  mem_msg_if.src             rsp_o
);

  import mem_msg_pkg::*;
  import tile_map_pkg::*;

  logic       accept;
  logic       is_write;
  logic [3:0] reg_idx;
  data_t      next_data;
  logic       next_err;
  logic       rsp_v_q;
  data_t      scratch0_q;
  data_t      scratch1_q;
  mem_op_e    op_q;
  addr_t      addr_q;
  data_t      data_q;
  tag_t       tag_q;
  logic       err_q;

  assign req_i.ready = !rsp_v_q || rsp_o.ready;
  assign accept      = req_i.v && req_i.ready;
  assign is_write    = (req_i.op == OP_WRITE);
  assign reg_idx     = req_i.addr[3:0];

  always_comb
  begin
    next_data = '0;
    next_err  = 1'b0;
    case (reg_idx)
      CFG_REG_ID:
      begin
        // Tile id is read only
        if (is_write)
          next_err = 1'b1;
        else
          next_data = data_t'(did_i);
      end
      CFG_REG_SCRATCH0:
      begin
        if (!is_write)
          next_data = scratch0_q;
      end
      CFG_REG_SCRATCH1:
      begin
        if (!is_write)
          next_data = scratch1_q;
      end
      default:
        next_err = 1'b1;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      rsp_v_q    <= 1'b0;
      scratch0_q <= '0;
      scratch1_q <= '0;
    end
    else
    begin
      if (accept)
        rsp_v_q <= 1'b1;
      else if (rsp_o.ready)
        rsp_v_q <= 1'b0;
      if (accept && is_write && (reg_idx == CFG_REG_SCRATCH0))
        scratch0_q <= req_i.data;
      if (accept && is_write && (reg_idx == CFG_REG_SCRATCH1))
        scratch1_q <= req_i.data;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (accept)
    begin
      op_q   <= req_i.op;
      addr_q <= req_i.addr;
      data_q <= next_data;
      tag_q  <= req_i.tag;
      err_q  <= next_err;
    end
  end

  assign rsp_o.v    = rsp_v_q;
  assign rsp_o.op   = op_q;
  assign rsp_o.addr = addr_q;
  assign rsp_o.data = data_q;
  assign rsp_o.tag  = tag_q;
  assign rsp_o.err  = err_q;

  a_rsp_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rsp_o.v && !rsp_o.ready |=>
      rsp_o.v && $stable({rsp_o.op, rsp_o.addr, rsp_o.data, rsp_o.tag, rsp_o.err}));

endmodule

// File: loopback_dev.sv
`timescale 1ns/10ps

module loopback_dev
(
  input  logic   clk_i,
  input  logic   rst_n_i,
  mem_msg_if.snk req_i,
  mem_msg_if.src rsp_o
);

  import mem_msg_pkg::*;

  logic    accept;
  logic    rsp_v_q;
  mem_op_e op_q;
  addr_t   addr_q;
  tag_t    tag_q;

  assign req_i.ready = !rsp_v_q || rsp_o.ready;
  assign accept      = req_i.v && req_i.ready;

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
      rsp_v_q <= 1'b0;
    else if (accept)
      rsp_v_q <= 1'b1;
    else if (rsp_o.ready)
      rsp_v_q <= 1'b0;
  end

  always_ff @(posedge clk_i)
  begin
    if (accept)
    begin
      op_q   <= req_i.op;
      addr_q <= req_i.addr;
      tag_q  <= req_i.tag;
    end
  end

  // Unmapped addresses always answer with an error and no data
  assign rsp_o.v    = rsp_v_q;
  assign rsp_o.op   = op_q;
  assign rsp_o.addr = addr_q;
  assign rsp_o.data = '0;
  assign rsp_o.tag  = tag_q;
  assign rsp_o.err  = 1'b1;

endmodule

// File: mem_slice.sv
`timescale 1ns/10ps

module mem_slice
#(
  parameter int MEM_DEPTH = 256
)
(
  input  logic   clk_i,
  input  logic   rst_n_i,
  mem_msg_if.snk req_i,
  mem_msg_if.src rsp_o
);

  import mem_msg_pkg::*;

  localparam int IDX_W = (MEM_DEPTH > 1) ? $clog2(MEM_DEPTH) : 1;

  logic             accept;
  logic             is_write;
  logic [IDX_W-1:0] mem_idx;
  data_t            mem_q [MEM_DEPTH];
  logic             rsp_v_q;
  mem_op_e          op_q;
  addr_t            addr_q;
  data_t            data_q;
  tag_t             tag_q;

  assign req_i.ready = !rsp_v_q || rsp_o.ready;
  assign accept      = req_i.v && req_i.ready;
  assign is_write    = (req_i.op == OP_WRITE);
  // Low address bits index the RAM and upper bits alias
  assign mem_idx     = req_i.addr[IDX_W-1:0];

  always_ff @(posedge clk_i)
  begin
    if (accept && is_write)
      mem_q[mem_idx] <= req_i.data;
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
      rsp_v_q <= 1'b0;
    else if (accept)
      rsp_v_q <= 1'b1;
    else if (rsp_o.ready)
      rsp_v_q <= 1'b0;
  end

  // Read data captured on the accepting edge and writes answer with zero
  always_ff @(posedge clk_i)
  begin
    if (accept)
    begin
      op_q   <= req_i.op;
      addr_q <= req_i.addr;
      tag_q  <= req_i.tag;
      data_q <= is_write ? '0 : mem_q[mem_idx];
    end
  end

  assign rsp_o.v    = rsp_v_q;
  assign rsp_o.op   = op_q;
  assign rsp_o.addr = addr_q;
  assign rsp_o.data = data_q;
  assign rsp_o.tag  = tag_q;
  assign rsp_o.err  = 1'b0;

  a_rsp_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rsp_o.v && !rsp_o.ready |=>
      rsp_o.v && $stable({rsp_o.op, rsp_o.addr, rsp_o.data, rsp_o.tag}));

endmodule

// File: mem_tile.sv
`timescale 1ns/10ps

module mem_tile
#(
  parameter int MEM_DEPTH   = 256,
  parameter int ORDER_DEPTH = 4
)
(
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  tile_map_pkg::did_t   did_i,

  input  logic                 req_v_i,
  input  mem_msg_pkg::mem_op_e req_op_i,
  input  mem_msg_pkg::addr_t   req_addr_i,
  input  mem_msg_pkg::data_t   req_data_i,
  input  mem_msg_pkg::tag_t    req_tag_i,
  output logic                 req_ready_o,

  output logic                 resp_v_o,
  output mem_msg_pkg::mem_op_e resp_op_o,
  output mem_msg_pkg::addr_t   resp_addr_o,
  output mem_msg_pkg::data_t   resp_data_o,
  output mem_msg_pkg::tag_t    resp_tag_o,
  output logic                 resp_err_o,
  input  logic                 resp_ready_i
);

  // One request and one response channel per device
  mem_msg_if mem_req ();
  mem_msg_if cfg_req ();
  mem_msg_if loop_req ();
  mem_msg_if mem_rsp ();
  mem_msg_if cfg_rsp ();
  mem_msg_if loop_rsp ();

  dev_xbar #(
    .ORDER_DEPTH (ORDER_DEPTH)
  ) u_xbar (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .req_v_i      (req_v_i),
    .req_op_i     (req_op_i),
    .req_addr_i   (req_addr_i),
    .req_data_i   (req_data_i),
    .req_tag_i    (req_tag_i),
    .req_ready_o  (req_ready_o),
    .resp_v_o     (resp_v_o),
    .resp_op_o    (resp_op_o),
    .resp_addr_o  (resp_addr_o),
    .resp_data_o  (resp_data_o),
    .resp_tag_o   (resp_tag_o),
    .resp_err_o   (resp_err_o),
    .resp_ready_i (resp_ready_i),
    .mem_req_o    (mem_req.src),
    .cfg_req_o    (cfg_req.src),
    .loop_req_o   (loop_req.src),
    .mem_rsp_i    (mem_rsp.snk),
    .cfg_rsp_i    (cfg_rsp.snk),
    .loop_rsp_i   (loop_rsp.snk)
  );

  mem_slice #(
    .MEM_DEPTH (MEM_DEPTH)
  ) u_mem (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .req_i   (mem_req.snk),
    .rsp_o   (mem_rsp.src)
  );

  cfg_slice u_cfg (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .did_i   (did_i),
    .req_i   (cfg_req.snk),
    .rsp_o   (cfg_rsp.src)
  );

  loopback_dev u_loop (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .req_i   (loop_req.snk),
    .rsp_o   (loop_rsp.src)
  );

endmodule

// File: tb_mem_tile.sv
`timescale 1ns/10ps

module tb_mem_tile;

  import mem_msg_pkg::*;
  import tile_map_pkg::*;

  localparam int MEM_DEPTH = 256;
  localparam int IDX_W = $clog2(MEM_DEPTH);
  localparam logic [7:0] TILE_ID = 8'h5a;
  // Well above the few hundred cycles that the tests take
  localparam int CYCLE_LIMIT = 4000;

  typedef struct packed
  {
    mem_op_e op;
    addr_t   addr;
    data_t   data;
    tag_t    tag;
    logic    err;
  } resp_t;

  logic    clk_i;
  logic    rst_n_i;
  did_t    did_i;
  logic    req_v_i;
  mem_op_e req_op_i;
  addr_t   req_addr_i;
  data_t   req_data_i;
  tag_t    req_tag_i;
  logic    req_ready_o;
  logic    resp_v_o;
  mem_op_e resp_op_o;
  addr_t   resp_addr_o;
  data_t   resp_data_o;
  tag_t    resp_tag_o;
  logic    resp_err_o;
  logic    resp_ready_i;

  logic [31:0] lfsr_q = 32'hcdd1d1ec;
  int          cycle_cnt = 0;
  logic        ready_mode = 1'b0;
  tag_t        tag_ctr = '0;
  resp_t       exp_q [$];
  data_t       ref_mem [MEM_DEPTH];
  logic        mem_known [MEM_DEPTH];
  data_t       ref_scratch0 = '0;
  data_t       ref_scratch1 = '0;
  addr_t       wr_addr [16];

  mem_tile #(
    .MEM_DEPTH   (MEM_DEPTH),
    .ORDER_DEPTH (4)
  ) UUT (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .did_i        (did_i),
    .req_v_i      (req_v_i),
    .req_op_i     (req_op_i),
    .req_addr_i   (req_addr_i),
    .req_data_i   (req_data_i),
    .req_tag_i    (req_tag_i),
    .req_ready_o  (req_ready_o),
    .resp_v_o     (resp_v_o),
    .resp_op_o    (resp_op_o),
    .resp_addr_o  (resp_addr_o),
    .resp_data_o  (resp_data_o),
    .resp_tag_o   (resp_tag_o),
    .resp_err_o   (resp_err_o),
    .resp_ready_i (resp_ready_i)
  );

  always #20 clk_i = ~clk_i;

  // Taps 32, 22, 2, 1
  function automatic logic next_bit();
    lfsr_q = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
    return lfsr_q[0];
  endfunction

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] r;
    int          k;
    r = '0;
    for (k = 0; k < n; k++)
      r = {r[30:0], next_bit()};
    return r;
  endfunction

  // 0 memory, 1 config, 2 loopback
  function automatic int target_of(input addr_t addr);
    if (addr[19])
      return 0;
    if (addr[18:16] == 3'd1)
      return 0;
    if (addr[18:16] == 3'd2)
      return 1;
    return 2;
  endfunction

  task automatic report_error(input string msg);
    $display("Error: time %0t: %s", $time, msg);
    $display("CHECKS FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic model_accept(input mem_op_e op, input addr_t addr, input data_t data,
                              input tag_t tag);
    resp_t e;
    e.op   = op;
    e.addr = addr;
    e.tag  = tag;
    e.data = '0;
    e.err  = 1'b0;
    case (target_of(addr))
      0:
      begin
        if (op == OP_WRITE)
          ref_mem[addr[IDX_W-1:0]] = data;
        else
          e.data = ref_mem[addr[IDX_W-1:0]];
      end
      1:
      begin
        case (addr[3:0])
          4'd0:
          begin
            if (op == OP_READ)
              e.data = {24'd0, TILE_ID};
            else
              e.err = 1'b1;
          end
          4'd1:
          begin
            if (op == OP_WRITE)
              ref_scratch0 = data;
            else
              e.data = ref_scratch0;
          end
          4'd2:
          begin
            if (op == OP_WRITE)
              ref_scratch1 = data;
            else
              e.data = ref_scratch1;
          end
          default:
            e.err = 1'b1;
        endcase
      end
      default:
        e.err = 1'b1;
    endcase
    exp_q.push_back(e);
  endtask

  // Starts on a falling edge and returns on the one after acceptance
  task automatic send_req(input mem_op_e op, input addr_t addr, input data_t data);
    req_v_i    = 1'b1;
    req_op_i   = op;
    req_addr_i = addr;
    req_data_i = data;
    req_tag_i  = tag_ctr;
    #1;
    while (!req_ready_o)
    begin
      @(negedge clk_i);
      #1;
    end
    model_accept(op, addr, data, tag_ctr);
    tag_ctr = tag_ctr + 4'd1;
    @(negedge clk_i);
    req_v_i = 1'b0;
  endtask

  task automatic check_response();
    resp_t got;
    resp_t exp;
    got = {resp_op_o, resp_addr_o, resp_data_o, resp_tag_o, resp_err_o};
    assert (exp_q.size() != 0)
    else
      report_error($sformatf("response tag %h with no request outstanding", got.tag));
    exp = exp_q.pop_front();
    assert (got === exp)
    else
      report_error($sformatf("expected op %0d addr %h data %h tag %h err %b, got %0d %h %h %h %b",
                             exp.op, exp.addr, exp.data, exp.tag, exp.err,
                             got.op, got.addr, got.data, got.tag, got.err));
  endtask

  task automatic wait_drain();
    while (exp_q.size() != 0)
      @(negedge clk_i);
  endtask

  // Drives the ready pattern and samples responses once inputs have settled
  always @(negedge clk_i)
  begin
    if (ready_mode)
      resp_ready_i = next_bit();
    else
      resp_ready_i = 1'b1;
    #1;
    if (rst_n_i && resp_v_o && resp_ready_i)
      check_response();
  end

  always @(posedge clk_i)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == CYCLE_LIMIT)
    begin
      $display("Timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
      $display("CHECKS FAILED");
      $fatal(1, "run stopped by timeout");
    end
  end

  task automatic memory_readback();
    logic [7:0] idx;
    int         i;
    for (i = 0; i < 16; i++)
    begin
      idx = 8'(i * 16) | 8'(take_bits(4));
      mem_known[idx] = 1'b1;
      if (i % 2 == 0)
        wr_addr[i] = {1'b1, 11'(take_bits(11)), idx};
      else
        wr_addr[i] = {4'b0001, 8'(take_bits(8)), idx};
      send_req(OP_WRITE, wr_addr[i], take_bits(32));
    end
    for (i = 0; i < 16; i++)
      send_req(OP_READ, wr_addr[i], take_bits(32));
    wait_drain();
  endtask

  task automatic config_access();
    send_req(OP_READ, 20'h20000, '0);
    send_req(OP_READ, 20'h20001, '0);
    send_req(OP_WRITE, 20'h20001, take_bits(32));
    send_req(OP_WRITE, 20'h20002, take_bits(32));
    send_req(OP_READ, 20'h20001, '0);
    send_req(OP_READ, 20'h20002, '0);
    send_req(OP_WRITE, 20'h20000, take_bits(32));
    send_req(OP_READ, 20'h20005, '0);
    send_req(OP_WRITE, 20'h20005, take_bits(32));
    wait_drain();
  endtask

  task automatic loopback_errors();
    send_req(OP_READ, {1'b0, 3'd0, 16'(take_bits(16))}, '0);
    send_req(OP_WRITE, {1'b0, 3'd3, 16'(take_bits(16))}, take_bits(32));
    send_req(OP_READ, {1'b0, 3'd7, 16'(take_bits(16))}, '0);
    wait_drain();
  endtask

  task automatic idle_latency();
    wait_drain();
    assert (resp_v_o === 1'b0)
    else
      report_error("resp_v_o high while the tile is idle");
    send_req(OP_READ, wr_addr[3], '0);
    assert (resp_v_o === 1'b1)
    else
      report_error("resp_v_o not high one cycle after acceptance");
    wait_drain();
  endtask

  task automatic mixed_ordering();
    mem_op_e    op_a [40];
    addr_t      addr_a [40];
    logic [7:0] idx;
    logic [2:0] field;
    int         i;
    for (i = 0; i < 40; i++)
    begin
      op_a[i] = (take_bits(1) != 0) ? OP_WRITE : OP_READ;
      case (take_bits(2))
        1:
          addr_a[i] = {4'b0010, 12'(take_bits(12)), 4'(take_bits(2))};
        2:
        begin
          field = 3'(take_bits(3));
          if (field == 3'd1 || field == 3'd2)
            field = 3'd7;
          addr_a[i] = {1'b0, field, 16'(take_bits(16))};
        end
        default:
        begin
          idx = 8'(take_bits(8));
          // Reads only where the word is known
          if (!mem_known[idx])
            op_a[i] = OP_WRITE;
          mem_known[idx] = 1'b1;
          if (take_bits(1) != 0)
            addr_a[i] = {1'b1, 11'(take_bits(11)), idx};
          else
            addr_a[i] = {4'b0001, 8'(take_bits(8)), idx};
        end
      endcase
    end
    @(posedge clk_i);
    ready_mode = 1'b1;
    @(negedge clk_i);
    for (i = 0; i < 40; i++)
      send_req(op_a[i], addr_a[i], take_bits(32));
    wait_drain();
    @(posedge clk_i);
    ready_mode = 1'b0;
    @(negedge clk_i);
  endtask

  initial
  begin
    clk_i        = 1'b0;
    rst_n_i      = 1'b0;
    did_i        = TILE_ID;
    req_v_i      = 1'b0;
    req_op_i     = OP_READ;
    req_addr_i   = '0;
    req_data_i   = '0;
    req_tag_i    = '0;
    resp_ready_i = 1'b1;
    for (int k = 0; k < MEM_DEPTH; k++)
      mem_known[k] = 1'b0;
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;
    @(negedge clk_i);
    assert (resp_v_o === 1'b0 && req_ready_o === 1'b1)
    else
      report_error("wrong handshake levels after reset");
    memory_readback();
    config_access();
    loopback_errors();
    idle_latency();
    mixed_ordering();
    assert (resp_v_o === 1'b0 && req_ready_o === 1'b1)
    else
      report_error("tile not idle after the last response was taken");
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

// File: flist.f
mem_msg_pkg.sv
tile_map_pkg.sv
mem_msg_if.sv
dev_xbar.sv
cfg_slice.sv
loopback_dev.sv
mem_slice.sv
mem_tile.sv
tb_mem_tile.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the mem_tile testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_mem_tile -f flist.f -o sim_mem_tile
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/sim_mem_tile)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "ALL CHECKS PASSED"; then
  exit 0
fi
echo "Pass message not found"
exit 1
